// ==== hdl/bitram_geom_pkg.sv ====
// bitram geometry package with the word and address widths and their vector types

package bitram_geom_pkg;

   // bits held in one scratchpad word
   localparam int word_width_lp = 32;

   // number of words in the RAM
   localparam int depth_lp = 64;

   // address width follows from the depth so the two never drift apart
   localparam int addr_width_lp = $clog2(depth_lp);

   // one word of data, also used for bit masks and the column-protect value
   typedef logic [word_width_lp-1:0] word_t;

   // word index into the RAM
   typedef logic [addr_width_lp-1:0] addr_t;

endpackage : bitram_geom_pkg

// ==== hdl/bitram_cmd_pkg.sv ====
// bitram command package with the operation encoding and the engine FSM states

package bitram_cmd_pkg;

   // operation carried by each command on the req/ack handshake
   // every operation fetches the old word first and returns it to the requester
   typedef enum logic [2:0]
   {
      // fetch only, no write is issued
      op_read   = 3'd0,
      // masked bits take the requester's write data
      op_write  = 3'd1,
      // masked bits are forced to one, a fetch-and-set
      op_set    = 3'd2,
      // masked bits are forced to zero, a fetch-and-clear
      op_clear  = 3'd3,
      // masked bits are inverted
      op_toggle = 3'd4
   } op_e;

   // engine sequencer states
   typedef enum logic [1:0]
   {
      // waiting for req_i
      s_idle   = 2'd0,
      // read request is on the port, RAM registers the address at the next edge
      s_fetch  = 2'd1,
      // old word is on r_data, the write is issued and the ack is prepared
      s_modify = 2'd2,
      // ack_o is high until the requester drops req_i
      s_done   = 2'd3
   } eng_state_e;

endpackage : bitram_cmd_pkg

// ==== hdl/bitram_port_if.sv ====
// bitram RAM port bundle carrying one read port and one masked write port
`timescale 1ns/1ps

interface bitram_port_if
   import bitram_geom_pkg::*;
   ();

   // read request, the address is captured on an edge where r_v is high
   logic  r_v;
   addr_t r_addr;

   // read data, valid from the cycle after the accepted read address
   word_t r_data;

   // write request with a per-bit write enable
   logic  w_v;
   word_t w_mask;
   addr_t w_addr;
   word_t w_data;

   // the engine drives both requests and consumes the read data
   modport engine
   (
      output r_v,
      output r_addr,
      input  r_data,
      output w_v,
      output w_mask,
      output w_addr,
      output w_data
   );

   // the memory takes both requests and returns the read data
   modport mem
   (
      input  r_v,
      input  r_addr,
      output r_data,
      input  w_v,
      input  w_mask,
      input  w_addr,
      input  w_data
   );

endinterface : bitram_port_if

// ==== hdl/bitram_mem.sv ====
// bitram storage, a 1r1w synchronous RAM with registered read address and bit write enables
`timescale 1ns/1ps

module bitram_mem
   import bitram_geom_pkg::*;
#(
   parameter int width_p = word_width_lp,
   parameter int els_p   = depth_lp
)
(
   input logic        clk_i,
   input logic        reset_i,
   bitram_port_if.mem port
);

   // the word array itself
   // contents after power-up are undefined, software writes every word before use
   logic [width_p-1:0] mem_r [els_p];

   // latched read address
   addr_t r_addr_r;

   // the read address is latched on the edge and the array is muxed after it,
   // which gives read data exactly one cycle after the address edge
   // when no read is requested the latched address goes unknown, so the output
   // cannot silently follow later writes to the old location
   // a hardened RAM would not behave that way either
   always_ff @(posedge clk_i)
   begin
      if (port.r_v)
      begin
         r_addr_r <= port.r_addr;
      end
      else
      begin
         r_addr_r <= 'X;
      end
   end

   // read data comes straight from the array at the latched address
   assign port.r_data = mem_r[r_addr_r];

   // each bit is written only where both the write valid and its mask bit are set
   // the write lands on the edge, so a later read of the same address sees it
   always_ff @(posedge clk_i)
   begin
      for (int i = 0; i < width_p; i++)
      begin
         if (port.w_v && port.w_mask[i])
         begin
            mem_r[port.w_addr][i] <= port.w_data[i];
         end
      end
   end

   // the engine never reads and writes one address in the same cycle,
   // so there is no collision handling here

endmodule : bitram_mem

// ==== hdl/bitram_lock_regs.sv ====
// bitram lock registers holding the column-protect mask that steers the engine's write mask
`timescale 1ns/1ps

module bitram_lock_regs
   import bitram_geom_pkg::*;
(
   input  logic  clk_i,
   input  logic  reset_i,

   // load strobe and the new protect value
   input  logic  lock_we_i,
   input  word_t lock_data_i,

   // current protect mask towards the engine
   output word_t lock_o
);

   // a one in bit i protects column i of every word
   word_t lock_r;

   // reset unprotects every column
   // a load pulse takes the new value, visible one edge later
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         lock_r <= '0;
      end
      else if (lock_we_i)
      begin
         lock_r <= lock_data_i;
      end
   end

   // the mask is only changed between commands, so the engine sees a
   // steady value for the whole fetch-modify-write sequence
   assign lock_o = lock_r;

   // there is no readback path,
   // software keeps its own copy of the value it loaded

endmodule : bitram_lock_regs

// ==== hdl/bitram_engine.sv ====
// bitram engine, four-phase command front end and fetch-modify-write sequencer
`timescale 1ns/1ps

module bitram_engine
   import bitram_geom_pkg::*;
   import bitram_cmd_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,

   // command side of the four-phase handshake
   input  logic     req_i,
   input  op_e      op_i,
   input  addr_t    addr_i,
   input  word_t    mask_i,
   input  word_t    wdata_i,

   // column-protect mask from the lock registers
   input  word_t    lock_i,

   // response side, rdata_o holds the old word while ack_o is high
   output logic     ack_o,
   output word_t    rdata_o,

   // RAM port
   bitram_port_if.engine port
);

   eng_state_e state_r;
   eng_state_e state_n;

   // masked bits as the operation wants them, before merging with the old word
   word_t new_bits;

   // full word that goes to the RAM
   word_t new_word;

   // old word captured for the response
   word_t rdata_r;

   // sequencer
   // idle -> fetch on req_i, then fetch -> modify -> done unconditionally,
   // and done -> idle once the requester has dropped req_i
   always_comb
   begin
      state_n = state_r;
      unique case (state_r)
         s_idle:
         begin
            if (req_i)
            begin
               state_n = s_fetch;
            end
         end
         s_fetch:
         begin
            state_n = s_modify;
         end
         s_modify:
         begin
            state_n = s_done;
         end
         s_done:
         begin
            // holding req_i high keeps the engine parked here
            if (!req_i)
            begin
               state_n = s_idle;
            end
         end
         default:
         begin
            state_n = s_idle;
         end
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= s_idle;
      end
      else
      begin
         state_r <= state_n;
      end
   end

   // the read goes out for the single cycle spent in s_fetch,
   // so the RAM latches the address on the edge that enters s_modify
   // command inputs are stable while req_i is high, so they feed the port directly
   assign port.r_v    = (state_r == s_fetch);
   assign port.r_addr = addr_i;

   // new value of the masked bits, picked by the operation
   // toggle works from the old word now sitting on r_data
   always_comb
   begin
      unique case (op_i)
         op_write:  new_bits = wdata_i;
         op_set:    new_bits = '1;
         op_clear:  new_bits = '0;
         op_toggle: new_bits = ~port.r_data;
         default:   new_bits = port.r_data;
      endcase
   end

   // w_data carries the full merged word, the RAM only stores the bits under w_mask
   assign new_word = (port.r_data & ~mask_i) | (new_bits & mask_i);

   // one write in s_modify, skipped for a plain read
   // protected columns are taken out of the requester's mask
   assign port.w_v    = (state_r == s_modify) && (op_i != op_read);
   assign port.w_mask = mask_i & ~lock_i;
   assign port.w_addr = addr_i;
   assign port.w_data = new_word;

   // old word is grabbed on the same edge that commits the write and enters s_done
   always_ff @(posedge clk_i)
   begin
      if (state_r == s_modify)
      begin
         rdata_r <= port.r_data;
      end
   end

   assign rdata_o = rdata_r;

   // ack follows the registered state, so it rises three edges after req_i is
   // first seen and falls on the edge that sees req_i low in s_done
   assign ack_o = (state_r == s_done);

endmodule : bitram_engine

// ==== hdl/bitram_top.sv ====
// bitram top level joining the command engine, lock registers and scratchpad RAM
`timescale 1ns/1ps

module bitram_top
   import bitram_geom_pkg::*;
   import bitram_cmd_pkg::*;
(
   input  logic  clk_i,
   input  logic  reset_i,

   // four-phase command handshake
   input  logic  req_i,
   input  op_e   op_i,
   input  addr_t addr_i,
   input  word_t mask_i,
   input  word_t wdata_i,
   output logic  ack_o,
   output word_t rdata_o,

   // column-protect load port
   input  logic  lock_we_i,
   input  word_t lock_data_i
);

   // protect mask from the lock block into the engine
   word_t lock;

   // RAM port between engine and memory
   bitram_port_if port_if ();

   bitram_lock_regs lock_regs
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .lock_we_i   (lock_we_i),
      .lock_data_i (lock_data_i),
      .lock_o      (lock)
   );

   bitram_engine engine
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .req_i   (req_i),
      .op_i    (op_i),
      .addr_i  (addr_i),
      .mask_i  (mask_i),
      .wdata_i (wdata_i),
      .lock_i  (lock),
      .ack_o   (ack_o),
      .rdata_o (rdata_o),
      .port    (port_if.engine)
   );

   // default geometry from the package
   bitram_mem mem
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .port    (port_if.mem)
   );

endmodule : bitram_top

// ==== bench/bitram_properties.sv ====
// bitram checker holding a shadow word model and the handshake and RAM port rules
`timescale 1ns/1ps

module bitram_properties
   import bitram_geom_pkg::*;
   import bitram_cmd_pkg::*;
(
   input logic  clk_i,
   input logic  reset_i,
   input logic  req_i,
   input op_e   op_i,
   input addr_t addr_i,
   input word_t mask_i,
   input word_t wdata_i,
   input logic  lock_we_i,
   input word_t lock_data_i,
   input logic  ack_i,
   input word_t rdata_i,
   bitram_port_if port
);

   // failures seen so far, read by the testbench after each test
   int unsigned error_count = 0;

   // shadow copy of the RAM, plus the bits of each word that have a defined value
   word_t shadow [depth_lp];
   word_t known [depth_lp] = '{default: '0};

   logic  ack_q = 1'b0;
   word_t expected_old;
   word_t known_old;
   word_t eff_mask;
   word_t op_bits;

   // protect mask as loaded over the lock port, visible one edge after the strobe
   word_t lock_model;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         lock_model <= '0;
      end
      else if (lock_we_i)
      begin
         lock_model <= lock_data_i;
      end
   end

   assign expected_old = shadow[addr_i];
   assign known_old    = known[addr_i];

   // a read writes nothing, the other operations touch the unlocked masked bits
   assign eff_mask = (op_i == op_read) ? '0 : (mask_i & ~lock_model);

   always_comb
   begin
      case (op_i)
         op_write: op_bits = wdata_i;
         op_set:   op_bits = '1;
         op_clear: op_bits = '0;
         default:  op_bits = ~expected_old;
      endcase
   end

   // the model moves on at each rising ack, when the command is still on the inputs
   // inverting an undefined bit leaves it undefined, so toggle adds no known bits
   always_ff @(posedge clk_i)
   begin
      ack_q <= ack_i;
      if (ack_i && !ack_q)
      begin
         shadow[addr_i] <= (expected_old & ~eff_mask) | (op_bits & eff_mask);
         if (op_i != op_toggle)
         begin
            known[addr_i] <= known_old | eff_mask;
         end
      end
   end

   task automatic log_failure(input string msg);
      error_count++;
      $error("%s", msg);
   endtask

   ack_low_after_reset: assert property (@(posedge clk_i) reset_i |=> !ack_i)
      else log_failure("ack_o was high right after reset");

   ack_three_edges: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(req_i) |-> !ack_i [*3] ##1 ack_i)
      else log_failure("ack_o did not rise exactly three edges after req_i was seen");

   // ack stays up while req is held and drops one edge after req is seen low
   ack_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
      ack_i |=> (ack_i == $past(req_i)))
      else log_failure("ack_o did not follow req_i in the done phase");

   no_spurious_ack: assert property (@(posedge clk_i) disable iff (reset_i)
      !ack_i && !req_i |=> !ack_i)
      else log_failure("ack_o rose while req_i was low");

   rdata_holds: assert property (@(posedge clk_i) disable iff (reset_i)
      ack_i && $past(ack_i) |-> $stable(rdata_i))
      else log_failure("rdata_o changed while ack_o was high");

   quiet_while_acked: assert property (@(posedge clk_i) disable iff (reset_i)
      ack_i |-> !port.r_v && !port.w_v)
      else log_failure("RAM access issued while the engine waited for req_i to drop");

   lock_respected: assert property (@(posedge clk_i) disable iff (reset_i)
      port.w_v |-> (port.w_mask & lock_model) == '0)
      else log_failure("write mask reached a locked column");

   // only bits with a defined shadow value are compared
   fetch_matches_shadow: assert property (@(posedge clk_i) disable iff (reset_i)
      ack_i && !ack_q |-> ((rdata_i ^ expected_old) & known_old) == '0)
      else log_failure($sformatf("Mismatch at %0t: word %0d fetched %h, expected %h",
         $time, $sampled(addr_i), $sampled(rdata_i), $sampled(expected_old)));

endmodule : bitram_properties

bind bitram_top bitram_properties props
(
   .*,
   .ack_i   (ack_o),
   .rdata_i (rdata_o),
   .port    (port_if)
);

// ==== bench/bitram_tb.sv ====
// bitram testbench running fetch-modify-write commands over the four-phase handshake
`timescale 1ns/1ps

module bitram_tb
   import bitram_geom_pkg::*;
   import bitram_cmd_pkg::*;
();

   logic  clk_i = 1'b0;
   logic  reset_i;
   logic  req_i;
   op_e   op_i;
   addr_t addr_i;
   word_t mask_i;
   word_t wdata_i;
   logic  lock_we_i;
   word_t lock_data_i;
   logic  ack_o;
   word_t rdata_o;

   integer seed = 32'h6919_6764;
   int     tests_run = 0;
   int     tests_failed = 0;
   int     timeouts = 0;
   int     errors_before = 0;
   addr_t  a;

   always #20 clk_i = ~clk_i;

   bitram_top UUT (.*);

   // one full command, req_i stays high for hold extra cycles after ack_o
   task automatic run_cmd(input op_e c_op, input addr_t c_addr, input word_t c_mask,
                          input word_t c_wdata, input int hold);
      int waited;
      @(negedge clk_i);
      op_i = c_op;
      addr_i = c_addr;
      mask_i = c_mask;
      wdata_i = c_wdata;
      req_i = 1'b1;
      waited = 0;
      while (!ack_o && waited < 20)
      begin
         @(negedge clk_i);
         waited++;
      end
      if (!ack_o)
      begin
         $display("Timeout at %0t: ack_o never rose after req_i was raised", $time);
         timeouts++;
      end
      repeat (hold) @(negedge clk_i);
      req_i = 1'b0;
      waited = 0;
      while (ack_o && waited < 20)
      begin
         @(negedge clk_i);
         waited++;
      end
      if (ack_o)
      begin
         $display("Timeout at %0t: ack_o never fell after req_i was dropped", $time);
         timeouts++;
      end
   endtask

   // a modifying command on a random word, then a read so the result gets fetched
   task automatic modify_and_read(input op_e c_op);
      a = addr_t'($random(seed));
      run_cmd(c_op, a, word_t'($random(seed)), word_t'($random(seed)), 0);
      run_cmd(op_read, a, '0, '0, 0);
   endtask

   task automatic load_lock(input word_t value);
      @(negedge clk_i);
      lock_we_i = 1'b1;
      lock_data_i = value;
      @(negedge clk_i);
      lock_we_i = 1'b0;
   endtask

   task automatic finish_test(input string name);
      int fails;
      fails = UUT.props.error_count + timeouts - errors_before;
      tests_run++;
      if (fails != 0)
      begin
         tests_failed++;
      end
      $display("test %s %s, %0d failures", name, (fails == 0) ? "ok" : "FAILED", fails);
      errors_before = UUT.props.error_count + timeouts;
   endtask

   initial
   begin
      req_i = 1'b0;
      op_i = op_read;
      addr_i = '0;
      mask_i = '0;
      wdata_i = '0;
      lock_we_i = 1'b0;
      lock_data_i = '0;
      reset_i = 1'b1;
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;

      // idle cycles first, then plain fetches of undefined words
      repeat (4) @(negedge clk_i);
      run_cmd(op_read, 6'd0, '0, '0, 0);
      run_cmd(op_read, 6'd37, '0, '0, 0);
      finish_test("handshake");

      for (int i = 0; i < depth_lp; i++)
      begin
         run_cmd(op_write, addr_t'(i), '1, word_t'($random(seed)), 0);
      end
      for (int i = 0; i < depth_lp; i++)
      begin
         run_cmd(op_read, addr_t'(i), '0, '0, 0);
      end
      finish_test("full_writes");

      for (int i = 0; i < 16; i++)
      begin
         modify_and_read(op_write);
      end
      finish_test("masked_write");

      // set, clear and toggle in turn
      for (int i = 0; i < 24; i++)
      begin
         modify_and_read(op_e'(2 + i % 3));
      end
      finish_test("set_clr_toggle");

      load_lock(word_t'($random(seed)));
      for (int i = 0; i < 24; i++)
      begin
         modify_and_read(op_e'(1 + i % 4));
      end
      load_lock('0);
      for (int i = 0; i < 8; i++)
      begin
         modify_and_read(op_e'(1 + i % 4));
      end
      finish_test("lock");

      for (int i = 0; i < 8; i++)
      begin
         run_cmd(op_e'(i % 5), addr_t'($random(seed)), word_t'($random(seed)),
                 word_t'($random(seed)), 1 + $unsigned($random(seed)) % 8);
      end
      finish_test("back_pressure");

      $display("%0d tests run, %0d failed, %0d failures in total",
               tests_run, tests_failed, errors_before);
      if (tests_failed == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule : bitram_tb

// ==== bitram.f ====
hdl/bitram_geom_pkg.sv
hdl/bitram_cmd_pkg.sv
hdl/bitram_port_if.sv
hdl/bitram_mem.sv
hdl/bitram_lock_regs.sv
hdl/bitram_engine.sv
hdl/bitram_top.sv
bench/bitram_properties.sv
bench/bitram_tb.sv

// ==== Bender.yml ====
package:
  name: bitram

sources:
  - hdl/bitram_geom_pkg.sv
  - hdl/bitram_cmd_pkg.sv
  - hdl/bitram_port_if.sv
  - hdl/bitram_mem.sv
  - hdl/bitram_lock_regs.sv
  - hdl/bitram_engine.sv
  - hdl/bitram_top.sv
  - target: simulation
    files:
      - bench/bitram_properties.sv
      - bench/bitram_tb.sv
